// File: include/line_follower_defs.svh
`ifndef LINE_FOLLOWER_DEFS_SVH
`define LINE_FOLLOWER_DEFS_SVH

// one reflectance reading from the converter
`define LF_SENSOR_W 12

// motor duty value, also sets the pwm resolution
`define LF_DUTY_W 4

// node counter, wraps on overflow
`define LF_COUNT_W 8

// pwm period in clk_3125 cycles, 2**LF_DUTY_W
`define LF_PWM_STEPS 16

// threshold defaults loaded on reset
`define LF_NODE_LEVEL_RST 12'd1000
`define LF_ON_LEVEL_RST 12'd500
`define LF_OFF_LEVEL_RST 12'd200

// duty defaults loaded on reset
`define LF_DUTY_FAST_RST 4'd8
`define LF_DUTY_SLOW_RST 4'd3

`endif

// File: src/line_follower_pkg.sv
`include "line_follower_defs.svh"

package line_follower_pkg;

	// one sample of the three line sensors
	typedef struct packed {
		logic [`LF_SENSOR_W-1:0] left;
		logic [`LF_SENSOR_W-1:0] middle;
		logic [`LF_SENSOR_W-1:0] right;
	} sensor_frame_t;

	// live thresholds and duty levels
	typedef struct packed {
		logic [`LF_SENSOR_W-1:0] node_level;
		logic [`LF_SENSOR_W-1:0] on_level;
		logic [`LF_SENSOR_W-1:0] off_level;
		logic [`LF_DUTY_W-1:0]   duty_fast;
		logic [`LF_DUTY_W-1:0]   duty_slow;
	} steer_cfg_t;

	// h-bridge direction pairs plus duty per motor
	typedef struct packed {
		logic                  m1_a;
		logic                  m1_b;
		logic                  m2_a;
		logic                  m2_b;
		logic [`LF_DUTY_W-1:0] dc1;
		logic [`LF_DUTY_W-1:0] dc2;
	} motor_cmd_t;

	// steering states, stop only after reset
	typedef enum logic [2:0] {
		MODE_STOP        = 3'd0,
		MODE_STRAIGHT    = 3'd1,
		MODE_PIVOT_RIGHT = 3'd2,
		MODE_PIVOT_LEFT  = 3'd3,
		MODE_NODE_TURN   = 3'd4
	} steer_mode_e;

	// config register opcodes, codes 5..7 unused
	typedef enum logic [2:0] {
		CFG_NODE_LEVEL = 3'd0,
		CFG_ON_LEVEL   = 3'd1,
		CFG_OFF_LEVEL  = 3'd2,
		CFG_DUTY_FAST  = 3'd3,
		CFG_DUTY_SLOW  = 3'd4
	} cfg_addr_e;

endpackage

// File: src/steer_config_regs.sv
`include "line_follower_defs.svh"

module steer_config_regs (
	input  logic                          clk_3125,
	input  logic                          reset,
	input  logic                          cfg_write,
	input  line_follower_pkg::cfg_addr_e  cfg_addr,
	input  logic [`LF_SENSOR_W-1:0]       cfg_wdata,
	output line_follower_pkg::steer_cfg_t cfg
);

	// one field per opcode, new value seen the cycle after the write
	always_ff @(posedge clk_3125) begin
		if (reset) begin
			cfg.node_level <= `LF_NODE_LEVEL_RST;
			cfg.on_level   <= `LF_ON_LEVEL_RST;
			cfg.off_level  <= `LF_OFF_LEVEL_RST;
			cfg.duty_fast  <= `LF_DUTY_FAST_RST;
			cfg.duty_slow  <= `LF_DUTY_SLOW_RST;
		end else if (cfg_write) begin
			case (cfg_addr)
				// thresholds take the full word
				line_follower_pkg::CFG_NODE_LEVEL: begin
					cfg.node_level <= cfg_wdata;
				end
				line_follower_pkg::CFG_ON_LEVEL: begin
					cfg.on_level <= cfg_wdata;
				end
				line_follower_pkg::CFG_OFF_LEVEL: begin
					cfg.off_level <= cfg_wdata;
				end
				// duties keep only the low bits
				line_follower_pkg::CFG_DUTY_FAST: begin
					cfg.duty_fast <= cfg_wdata[`LF_DUTY_W-1:0];
				end
				line_follower_pkg::CFG_DUTY_SLOW: begin
					cfg.duty_slow <= cfg_wdata[`LF_DUTY_W-1:0];
				end
				// unused opcodes leave every field alone
				default: begin
				end
			endcase
		end
	end

	// configuration only moves on a write strobe
	a_cfg_stable: assert property (
		@(posedge clk_3125) disable iff (reset)
		!cfg_write |=> $stable(cfg)
	);

endmodule

// File: src/line_steering.sv
`include "line_follower_defs.svh"

module line_steering (
	input  logic                            clk_3125,
	input  logic                            reset,
	input  logic                            sample_valid,
	input  line_follower_pkg::sensor_frame_t sample,
	input  line_follower_pkg::steer_cfg_t   cfg,
	output line_follower_pkg::motor_cmd_t   cmd,
	output line_follower_pkg::steer_mode_e  mode,
	output logic                            node_flag,
	output logic [`LF_COUNT_W-1:0]          node_count
);

	// threshold compares on the incoming frame
	logic all_high;
	logic turn_right;
	logic turn_left;
	logic centred;

	// next state of every output register
	line_follower_pkg::motor_cmd_t  cmd_nxt;
	line_follower_pkg::steer_mode_e mode_nxt;
	logic                           flag_nxt;
	logic [`LF_COUNT_W-1:0]         count_nxt;

	// node crossing, every sensor on the line
	assign all_high = (sample.left > cfg.node_level) &&
		(sample.middle > cfg.node_level) &&
		(sample.right > cfg.node_level);

	// line drifted under the right sensor
	assign turn_right = (sample.right > cfg.on_level) && (sample.left < cfg.off_level);

	// line drifted under the left sensor
	assign turn_left = (sample.left > cfg.on_level) && (sample.right < cfg.off_level);

	// only the middle sensor sees the line
	assign centred = (sample.left < cfg.off_level) &&
		(sample.middle > cfg.on_level) &&
		(sample.right < cfg.off_level);

	// priority tree, first match wins, no match holds
	always_comb begin
		cmd_nxt   = cmd;
		mode_nxt  = mode;
		flag_nxt  = node_flag;
		count_nxt = node_count;
		if (all_high && !node_flag) begin
			// spin right at the node, count it once
			mode_nxt  = line_follower_pkg::MODE_NODE_TURN;
			cmd_nxt   = '{m1_a: 1'b1, m1_b: 1'b0, m2_a: 1'b0, m2_b: 1'b1,
				dc1: cfg.duty_fast, dc2: cfg.duty_slow};
			flag_nxt  = 1'b1;
			count_nxt = node_count + 1'b1;
		end else if (turn_right) begin
			// m1 forward fast, m2 reverse slow
			mode_nxt = line_follower_pkg::MODE_PIVOT_RIGHT;
			cmd_nxt  = '{m1_a: 1'b1, m1_b: 1'b0, m2_a: 1'b0, m2_b: 1'b1,
				dc1: cfg.duty_fast, dc2: cfg.duty_slow};
		end else if (turn_left) begin
			// mirror of the right pivot
			mode_nxt = line_follower_pkg::MODE_PIVOT_LEFT;
			cmd_nxt  = '{m1_a: 1'b0, m1_b: 1'b1, m2_a: 1'b1, m2_b: 1'b0,
				dc1: cfg.duty_slow, dc2: cfg.duty_fast};
		end else if (centred) begin
			// back on the line, rearm node detection
			mode_nxt = line_follower_pkg::MODE_STRAIGHT;
			cmd_nxt  = '{m1_a: 1'b1, m1_b: 1'b0, m2_a: 1'b1, m2_b: 1'b0,
				dc1: cfg.duty_fast, dc2: cfg.duty_fast};
			flag_nxt = 1'b0;
		end
	end

	// outputs only move on a sample strobe
	always_ff @(posedge clk_3125) begin
		if (reset) begin
			cmd        <= '0;
			mode       <= line_follower_pkg::MODE_STOP;
			node_flag  <= 1'b0;
			node_count <= '0;
		end else if (sample_valid) begin
			cmd        <= cmd_nxt;
			mode       <= mode_nxt;
			node_flag  <= flag_nxt;
			node_count <= count_nxt;
		end
	end

	// a bridge is never driven both ways
	a_no_shoot_through: assert property (
		@(posedge clk_3125) disable iff (reset)
		!(cmd.m1_a && cmd.m1_b) && !(cmd.m2_a && cmd.m2_b)
	);

	// count moves only together with a fresh node latch
	a_count_on_node: assert property (
		@(posedge clk_3125) disable iff (reset)
		(node_count != $past(node_count)) && !$past(reset) |-> $rose(node_flag)
	);

endmodule

// File: src/motor_pwm.sv
`include "line_follower_defs.svh"

module motor_pwm (
	input  logic                          clk_3125,
	input  logic                          reset,
	input  line_follower_pkg::motor_cmd_t cmd,
	output logic                          pwm1,
	output logic                          pwm2
);

	// last count value of one pwm period
	localparam logic [`LF_DUTY_W-1:0] pwm_last = `LF_DUTY_W'(`LF_PWM_STEPS - 1);

	// free-running period counter
	logic [`LF_DUTY_W-1:0] pwm_cnt;

	always_ff @(posedge clk_3125) begin
		if (reset) begin
			pwm_cnt <= '0;
		end else if (pwm_cnt == pwm_last) begin
			pwm_cnt <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
		end
	end

	// high for dc counts out of each period
	always_ff @(posedge clk_3125) begin
		if (reset) begin
			pwm1 <= 1'b0;
			pwm2 <= 1'b0;
		end else begin
			pwm1 <= (pwm_cnt < cmd.dc1);
			pwm2 <= (pwm_cnt < cmd.dc2);
		end
	end

	// zero duty keeps the enable low on the next cycle
	a_pwm1_off: assert property (
		@(posedge clk_3125) disable iff (reset)
		(cmd.dc1 == '0) |=> !pwm1
	);

	a_pwm2_off: assert property (
		@(posedge clk_3125) disable iff (reset)
		(cmd.dc2 == '0) |=> !pwm2
	);

endmodule

// File: src/line_follower_top.sv
`include "line_follower_defs.svh"

module line_follower_top (
	input  logic                            clk_3125,
	input  logic                            reset,
	input  logic                            sample_valid,
	input  line_follower_pkg::sensor_frame_t sample,
	input  logic                            cfg_write,
	input  line_follower_pkg::cfg_addr_e    cfg_addr,
	input  logic [`LF_SENSOR_W-1:0]         cfg_wdata,
	output line_follower_pkg::motor_cmd_t   cmd,
	output line_follower_pkg::steer_mode_e  mode,
	output logic                            node_flag,
	output logic [`LF_COUNT_W-1:0]          node_count,
	output logic                            pwm1,
	output logic                            pwm2
);

	// live thresholds and duties
	line_follower_pkg::steer_cfg_t cfg;

	steer_config_regs u_cfg (
		.clk_3125  (clk_3125),
		.reset     (reset),
		.cfg_write (cfg_write),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg       (cfg)
	);

	// decision logic, also feeds the pwm duties
	line_steering u_steer (
		.clk_3125     (clk_3125),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.cfg          (cfg),
		.cmd          (cmd),
		.mode         (mode),
		.node_flag    (node_flag),
		.node_count   (node_count)
	);

	motor_pwm u_pwm (
		.clk_3125 (clk_3125),
		.reset    (reset),
		.cmd      (cmd),
		.pwm1     (pwm1),
		.pwm2     (pwm2)
	);

endmodule

// File: tests/line_follower_tb.sv
`include "line_follower_defs.svh"

module line_follower_tb;

	logic                             clk_3125;
	logic                             reset;
	logic                             sample_valid;
	line_follower_pkg::sensor_frame_t sample;
	logic                             cfg_write;
	line_follower_pkg::cfg_addr_e     cfg_addr;
	logic [`LF_SENSOR_W-1:0]          cfg_wdata;
	line_follower_pkg::motor_cmd_t    cmd;
	line_follower_pkg::steer_mode_e   mode;
	logic                             node_flag;
	logic [`LF_COUNT_W-1:0]           node_count;
	logic                             pwm1;
	logic                             pwm2;

	// reference model state
	line_follower_pkg::steer_cfg_t  m_cfg;
	line_follower_pkg::motor_cmd_t  m_cmd;
	line_follower_pkg::steer_mode_e m_mode;
	logic                           m_flag;
	logic [`LF_COUNT_W-1:0]         m_count;

	int pass_count;
	int fail_count;

	line_follower_top UUT (.*);

	initial clk_3125 = 1'b0;
	always #10 clk_3125 = ~clk_3125;

	// hard stop if the run wanders off
	initial begin
		repeat (20000) @(posedge clk_3125);
		$display("timeout: simulation did not reach the end of the test sequence");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	// uniform pick in [lo, hi]
	// an empty range collapses to lo
	function automatic logic [`LF_SENSOR_W-1:0] pick_in(input int lo, input int hi);
		if (lo > 4095)
			lo = 4095;
		if (hi < lo)
			return `LF_SENSOR_W'(lo);
		return `LF_SENSOR_W'($urandom_range(hi, lo));
	endfunction

	// reading that lands in one of the threshold bands
	function automatic logic [`LF_SENSOR_W-1:0] biased_reading();
		case ($urandom_range(3, 0))
			0: return pick_in(0, int'(m_cfg.off_level) - 1);
			1: return pick_in(m_cfg.off_level, m_cfg.on_level);
			2: return pick_in(int'(m_cfg.on_level) + 1, m_cfg.node_level);
			default: return pick_in(int'(m_cfg.node_level) + 1, 4095);
		endcase
	endfunction

	function automatic line_follower_pkg::sensor_frame_t node_frame();
		line_follower_pkg::sensor_frame_t f;
		f.left = pick_in(int'(m_cfg.node_level) + 1, 4095);
		f.middle = pick_in(int'(m_cfg.node_level) + 1, 4095);
		f.right = pick_in(int'(m_cfg.node_level) + 1, 4095);
		return f;
	endfunction

	// left and right off the line, middle on it
	function automatic line_follower_pkg::sensor_frame_t centred_frame();
		line_follower_pkg::sensor_frame_t f;
		f.left = pick_in(0, int'(m_cfg.off_level) - 1);
		f.middle = pick_in(int'(m_cfg.on_level) + 1, 4095);
		f.right = pick_in(0, int'(m_cfg.off_level) - 1);
		return f;
	endfunction

	function automatic line_follower_pkg::sensor_frame_t random_frame();
		line_follower_pkg::sensor_frame_t f;
		int kind;
		kind = $urandom_range(9, 0);
		f.left = biased_reading();
		f.middle = biased_reading();
		f.right = biased_reading();
		// extra weight on nodes and centred frames
		if (kind < 2)
			f = node_frame();
		else if (kind < 4)
			f = centred_frame();
		return f;
	endfunction

	// decision rules in priority order
	task automatic model_sample(input line_follower_pkg::sensor_frame_t s);
		logic [`LF_SENSOR_W-1:0] node_lvl;
		logic [`LF_SENSOR_W-1:0] on_lvl;
		logic [`LF_SENSOR_W-1:0] off_lvl;
		node_lvl = m_cfg.node_level;
		on_lvl = m_cfg.on_level;
		off_lvl = m_cfg.off_level;
		if (s.left > node_lvl && s.middle > node_lvl && s.right > node_lvl && !m_flag) begin
			m_mode = line_follower_pkg::MODE_NODE_TURN;
			m_cmd = '{1'b1, 1'b0, 1'b0, 1'b1, m_cfg.duty_fast, m_cfg.duty_slow};
			m_flag = 1'b1;
			m_count = m_count + 1'b1;
		end else if (s.right > on_lvl && s.left < off_lvl) begin
			m_mode = line_follower_pkg::MODE_PIVOT_RIGHT;
			m_cmd = '{1'b1, 1'b0, 1'b0, 1'b1, m_cfg.duty_fast, m_cfg.duty_slow};
		end else if (s.left > on_lvl && s.right < off_lvl) begin
			m_mode = line_follower_pkg::MODE_PIVOT_LEFT;
			m_cmd = '{1'b0, 1'b1, 1'b1, 1'b0, m_cfg.duty_slow, m_cfg.duty_fast};
		end else if (s.left < off_lvl && s.middle > on_lvl && s.right < off_lvl) begin
			m_mode = line_follower_pkg::MODE_STRAIGHT;
			m_cmd = '{1'b1, 1'b0, 1'b1, 1'b0, m_cfg.duty_fast, m_cfg.duty_fast};
			m_flag = 1'b0;
		end
	endtask

	task automatic model_write(input line_follower_pkg::cfg_addr_e addr,
		input logic [`LF_SENSOR_W-1:0] data);
		case (addr)
			line_follower_pkg::CFG_NODE_LEVEL: m_cfg.node_level = data;
			line_follower_pkg::CFG_ON_LEVEL: m_cfg.on_level = data;
			line_follower_pkg::CFG_OFF_LEVEL: m_cfg.off_level = data;
			line_follower_pkg::CFG_DUTY_FAST: m_cfg.duty_fast = data[`LF_DUTY_W-1:0];
			line_follower_pkg::CFG_DUTY_SLOW: m_cfg.duty_slow = data[`LF_DUTY_W-1:0];
			default: ;
		endcase
	endtask

	// thresholds kept ordered so every rule stays reachable
	function automatic logic [`LF_SENSOR_W-1:0] cfg_value(
		input line_follower_pkg::cfg_addr_e addr);
		case (addr)
			line_follower_pkg::CFG_NODE_LEVEL: return pick_in(2000, 3500);
			line_follower_pkg::CFG_ON_LEVEL: return pick_in(600, 1500);
			line_follower_pkg::CFG_OFF_LEVEL: return pick_in(100, 500);
			default: return `LF_SENSOR_W'($urandom);
		endcase
	endfunction

	// one clock of stimulus
	// entered and left 2 units after the rising edge
	task automatic drive_cycle(input logic valid, input line_follower_pkg::sensor_frame_t s,
		input logic write, input line_follower_pkg::cfg_addr_e addr,
		input logic [`LF_SENSOR_W-1:0] data);
		sample_valid = valid;
		sample = s;
		cfg_write = write;
		cfg_addr = addr;
		cfg_wdata = data;
		// sample decided on the config from before this write
		if (valid)
			model_sample(s);
		if (write)
			model_write(addr, data);
		@(posedge clk_3125);
		#2;
		sample_valid = 1'b0;
		cfg_write = 1'b0;
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, random_frame(), 1'b0, line_follower_pkg::CFG_NODE_LEVEL, '0);
	endtask

	task automatic compare_outputs(input string tag);
		check_value({tag, " cmd"}, m_cmd, cmd);
		check_value({tag, " mode"}, m_mode, mode);
		check_value({tag, " node_flag"}, m_flag, node_flag);
		check_value({tag, " node_count"}, m_count, node_count);
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("test %s finished with %0d errors", name, fail_count - fails_before);
	endtask

	// wait for either enable to go high
	// bounded by two pwm periods
	task automatic wait_pwm_active();
		int cycles;
		cycles = 0;
		while (!pwm1 && !pwm2 && cycles < 2 * `LF_PWM_STEPS) begin
			@(posedge clk_3125);
			#2;
			cycles++;
		end
		if (!pwm1 && !pwm2) begin
			$display("timeout: no pwm enable went high within %0d cycles", cycles);
			fail_count++;
		end
	endtask

	initial begin
		int fails_before;
		int highs1;
		int highs2;
		logic [`LF_COUNT_W-1:0] count_start;
		line_follower_pkg::cfg_addr_e addr;
		line_follower_pkg::sensor_frame_t f;

		void'($urandom(2));
		pass_count = 0;
		fail_count = 0;
		reset = 1'b1;
		sample_valid = 1'b0;
		sample = '0;
		cfg_write = 1'b0;
		cfg_addr = line_follower_pkg::CFG_NODE_LEVEL;
		cfg_wdata = '0;
		m_cfg = '{`LF_NODE_LEVEL_RST, `LF_ON_LEVEL_RST, `LF_OFF_LEVEL_RST,
			`LF_DUTY_FAST_RST, `LF_DUTY_SLOW_RST};
		m_cmd = '0;
		m_mode = line_follower_pkg::MODE_STOP;
		m_flag = 1'b0;
		m_count = '0;
		repeat (3) @(posedge clk_3125);
		#2;
		reset = 1'b0;

		// reset state with enables low for a full period
		fails_before = fail_count;
		compare_outputs("reset");
		highs1 = 0;
		highs2 = 0;
		repeat (`LF_PWM_STEPS) begin
			highs1 += pwm1;
			highs2 += pwm2;
			idle_cycle();
		end
		check_value("reset pwm1 highs", 0, highs1);
		check_value("reset pwm2 highs", 0, highs2);
		report_test("reset_state", fails_before);

		// random strobes with random gaps on defaults
		fails_before = fail_count;
		repeat (300) begin
			repeat ($urandom_range(3, 0))
				idle_cycle();
			drive_cycle(1'b1, random_frame(), 1'b0, line_follower_pkg::CFG_NODE_LEVEL, '0);
			compare_outputs("default");
		end
		report_test("default_decisions", fails_before);

		// reprogram every register, then strobes with overlapping writes
		fails_before = fail_count;
		for (int a = 0; a < 5; a++) begin
			addr = line_follower_pkg::cfg_addr_e'(a);
			drive_cycle(1'b0, random_frame(), 1'b1, addr, cfg_value(addr));
		end
		repeat (200) begin
			addr = line_follower_pkg::cfg_addr_e'($urandom_range(7, 0));
			drive_cycle(1'b1, random_frame(), $urandom_range(9, 0) < 3, addr, cfg_value(addr));
			compare_outputs("reprogrammed");
		end
		report_test("reprogrammed_config", fails_before);

		// node runs counted once each and rearmed by a centred frame
		fails_before = fail_count;
		drive_cycle(1'b1, centred_frame(), 1'b0, line_follower_pkg::CFG_NODE_LEVEL, '0);
		compare_outputs("node start");
		count_start = m_count;
		for (int run = 1; run <= 5; run++) begin
			repeat ($urandom_range(5, 2)) begin
				drive_cycle(1'b1, node_frame(), 1'b0, line_follower_pkg::CFG_NODE_LEVEL, '0);
				compare_outputs("node run");
			end
			check_value("node_count after run", `LF_COUNT_W'(count_start + run), node_count);
			check_value("node_flag in run", 1, node_flag);
			drive_cycle(1'b1, centred_frame(), 1'b0, line_follower_pkg::CFG_NODE_LEVEL, '0);
			check_value("node_flag after centre", 0, node_flag);
		end
		report_test("node_counting", fails_before);

		// outputs hold while sample moves without a strobe
		fails_before = fail_count;
		repeat (20) begin
			idle_cycle();
			compare_outputs("hold");
		end
		report_test("hold_without_strobe", fails_before);

		// enable high count per period matches the duty
		fails_before = fail_count;
		for (int i = 0; i < 6; i++) begin
			drive_cycle(1'b0, random_frame(), 1'b1, line_follower_pkg::CFG_DUTY_FAST,
				(i == 0) ? 12'd15 : cfg_value(line_follower_pkg::CFG_DUTY_FAST));
			drive_cycle(1'b0, random_frame(), 1'b1, line_follower_pkg::CFG_DUTY_SLOW,
				(i == 1) ? 12'd0 : cfg_value(line_follower_pkg::CFG_DUTY_SLOW));
			f = centred_frame();
			if (i % 3 == 1) begin
				f.right = pick_in(int'(m_cfg.on_level) + 1, 4095);
			end else if (i % 3 == 2) begin
				f.left = pick_in(int'(m_cfg.on_level) + 1, 4095);
			end
			drive_cycle(1'b1, f, 1'b0, line_follower_pkg::CFG_NODE_LEVEL, '0);
			compare_outputs("pwm command");
			repeat (`LF_PWM_STEPS)
				idle_cycle();
			if (m_cmd.dc1 != 0 || m_cmd.dc2 != 0)
				wait_pwm_active();
			highs1 = 0;
			highs2 = 0;
			repeat (`LF_PWM_STEPS) begin
				highs1 += pwm1;
				highs2 += pwm2;
				idle_cycle();
			end
			check_value("pwm1 high cycles", m_cmd.dc1, highs1);
			check_value("pwm2 high cycles", m_cmd.dc2, highs2);
		end
		report_test("pwm_duty", fails_before);

		$display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+include
src/line_follower_pkg.sv
src/steer_config_regs.sv
src/line_steering.sv
src/motor_pwm.sv
src/line_follower_top.sv
tests/line_follower_tb.sv

// File: Bender.yml
package:
  name: line_follower

sources:
  - include_dirs:
      - include
    files:
      - src/line_follower_pkg.sv
      - src/steer_config_regs.sv
      - src/line_steering.sv
      - src/motor_pwm.sv
      - src/line_follower_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/line_follower_tb.sv
